/* logic/display_settings.svh */
`ifndef DISPLAY_SETTINGS_SVH
`define DISPLAY_SETTINGS_SVH

// Scan-out words per frame (64 bits each)
`define FRAME_WORDS 34560

// Colour byte and memory word widths
`define PIXEL_BITS 8
`define WRITE_BITS 32
`define READ_BITS 64

// Colour bytes packed into one write word
`define PIXELS_PER_WORD 4

// Word addresses on each port
`define READ_ADDR_BITS 16
`define WRITE_ADDR_BITS 17

`endif

/* logic/displayPkg.sv */
`default_nettype none

`include "display_settings.svh"

package displayPkg;

    // One pixel colour as the graphics side delivers it
    typedef logic [`PIXEL_BITS-1:0] colorByte_t;

    // Memory words on the write and read ports
    typedef logic [`WRITE_BITS-1:0] writeWord_t;
    typedef logic [`READ_BITS-1:0]  readWord_t;

    // Word addresses, write side counts 32-bit words
    typedef logic [`WRITE_ADDR_BITS-1:0] writeAddr_t;
    typedef logic [`READ_ADDR_BITS-1:0]  readAddr_t;

endpackage

`default_nettype wire

/* logic/pixelPacker.sv */
`default_nettype none

`include "display_settings.svh"

module pixelPacker import displayPkg::*; (
    input  logic       USER_CLK,
    input  logic       nRES_L,
    input  logic       frameStart,
    input  logic       pixelValid,
    input  colorByte_t pixelColor,
    output logic       writeEnable,
    output writeAddr_t writeAddr,
    output writeWord_t writeData
);

    localparam int countBits = $clog2(`PIXELS_PER_WORD);
    localparam logic [countBits-1:0] lastByte = countBits'(`PIXELS_PER_WORD - 1);
    localparam writeAddr_t lastWriteAddr = writeAddr_t'(2 * `FRAME_WORDS - 1);

    logic [countBits-1:0] byteCount;   // Bytes already held in shiftWord
    writeWord_t           shiftWord;
    writeWord_t           nextWord;
    logic                 wordDone;

    // Newest byte enters at the top, so the first one ends in bits 7:0
    assign nextWord = {pixelColor, shiftWord[`WRITE_BITS-1:`PIXEL_BITS]};

    // frameStart wins over a pixel in the same cycle
    assign wordDone = pixelValid && !frameStart && (byteCount == lastByte);

    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            byteCount   <= '0;
            writeEnable <= 1'b0;
        end else begin
            writeEnable <= wordDone;
            if (frameStart || wordDone) begin
                byteCount <= '0;   // Partial group is dropped
            end else if (pixelValid) begin
                byteCount <= byteCount + 1'b1;
            end
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (pixelValid) begin
            shiftWord <= nextWord;
        end
        if (wordDone) begin
            writeData <= nextWord;   // Held for the write strobe cycle
        end
    end

    // Address of the next write word
    // Steps once the buffer has taken the current word
    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            writeAddr <= '0;
        end else if (frameStart) begin
            writeAddr <= '0;
        end else if (writeEnable) begin
            if (writeAddr == lastWriteAddr) begin
                writeAddr <= '0;
            end else begin
                writeAddr <= writeAddr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/displayBuffer.sv */
`default_nettype none

`include "display_settings.svh"

module displayBuffer import displayPkg::*; (
    input  logic       USER_CLK,
    input  logic       writeEnable,
    input  writeAddr_t writeAddr,
    input  writeWord_t writeData,
    input  logic       readEnable,
    input  readAddr_t  readAddr,
    output readWord_t  readData
);

    // Index bits actually needed for one bank
    localparam int bankBits = $clog2(`FRAME_WORDS);

    // Even write words form the low half of a read word, odd words the high half.
    // Splitting them lets one read address fetch both halves at once.
    writeWord_t evenBank [`FRAME_WORDS];
    writeWord_t oddBank  [`FRAME_WORDS];

    logic [bankBits-1:0] writeIndex;
    logic [bankBits-1:0] readIndex;
    logic                oddWord;

    assign oddWord    = writeAddr[0];
    assign writeIndex = writeAddr[bankBits:1];
    assign readIndex  = readAddr[bankBits-1:0];

    always_ff @(posedge USER_CLK) begin
        if (writeEnable) begin
            if (oddWord) begin
                oddBank[writeIndex] <= writeData;
            end else begin
                evenBank[writeIndex] <= writeData;
            end
        end
    end

    // Registered read port, one cycle of latency
    always_ff @(posedge USER_CLK) begin
        if (readEnable) begin
            readData <= {oddBank[readIndex], evenBank[readIndex]};
        end
    end

endmodule

`default_nettype wire

/* logic/scanoutReader.sv */
`default_nettype none

`include "display_settings.svh"

module scanoutReader import displayPkg::*; (
    input  logic      USER_CLK,
    input  logic      nRES_L,
    input  logic      request,
    output logic      readEnable,
    output readAddr_t readAddr,
    input  readWord_t readData,
    output readWord_t scanData,
    output logic      scanValid
);

    localparam readAddr_t lastReadAddr = readAddr_t'(`FRAME_WORDS - 1);

    logic readPending;   // Buffer output holds a requested word

    // Each request reads straight away at the current address
    assign readEnable = request;

    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            readAddr    <= '0;
            readPending <= 1'b0;
            scanValid   <= 1'b0;
        end else begin
            readPending <= request;
            scanValid   <= readPending;
            if (request) begin
                // Wrap at the frame's last word
                if (readAddr == lastReadAddr) begin
                    readAddr <= '0;
                end else begin
                    readAddr <= readAddr + 1'b1;
                end
            end
        end
    end

    // Second pipeline stage, keeps up with a request every cycle
    always_ff @(posedge USER_CLK) begin
        if (readPending) begin
            scanData <= readData;
        end
    end

endmodule

`default_nettype wire

/* logic/displayPath.sv */
`default_nettype none

module displayPath import displayPkg::*; (
    input  logic       USER_CLK,
    input  logic       nRES_L,
    input  logic       frameStart,
    input  logic       pixelValid,
    input  colorByte_t pixelColor,
    input  logic       request,
    output readWord_t  scanData,
    output logic       scanValid
);

    // Write port, from the packer
    logic       writeEnable;
    writeAddr_t writeAddr;
    writeWord_t writeData;

    // Read port, owned by the scan-out side
    logic       readEnable;
    readAddr_t  readAddr;
    readWord_t  readData;

    pixelPacker packer (
        .USER_CLK    (USER_CLK),
        .nRES_L      (nRES_L),
        .frameStart  (frameStart),
        .pixelValid  (pixelValid),
        .pixelColor  (pixelColor),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

    displayBuffer buffer (
        .USER_CLK    (USER_CLK),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .readEnable  (readEnable),
        .readAddr    (readAddr),
        .readData    (readData)
    );

    scanoutReader reader (
        .USER_CLK    (USER_CLK),
        .nRES_L      (nRES_L),
        .request     (request),
        .readEnable  (readEnable),
        .readAddr    (readAddr),
        .readData    (readData),
        .scanData    (scanData),
        .scanValid   (scanValid)
    );

endmodule

`default_nettype wire

/* testbench/displayPath_props.sv */
`default_nettype none

module displayPath_props import displayPkg::*; (
    input logic      USER_CLK,
    input logic      nRES_L,
    input logic      request,
    input logic      scanValid,
    input readWord_t scanData
);

    // Every request comes back exactly two cycles later
    requestServed: assert property (
        @(posedge USER_CLK) disable iff (nRES_L)
        $past(request, 2) |-> scanValid
    ) else $error("request was not answered by scanValid two cycles later");

    // No scanValid without a request two cycles earlier
    noStrayValid: assert property (
        @(posedge USER_CLK) disable iff (nRES_L)
        scanValid |-> $past(request, 2)
    ) else $error("scanValid without a request two cycles earlier");

    // Quiet output in reset and just after release
    resetQuiet: assert property (
        @(posedge USER_CLK)
        ($past(nRES_L) || $past(nRES_L, 2)) |-> !scanValid
    ) else $error("scanValid high during or right after reset");

    // Words read are always written first, so no X may leak out
    dataKnown: assert property (
        @(posedge USER_CLK) disable iff (nRES_L)
        scanValid |-> !$isunknown(scanData)
    ) else $error("scanData has unknown bits while scanValid is high");

endmodule

`default_nettype wire

/* testbench/displayPath_tb.sv */
`default_nettype none

`include "display_settings.svh"

module displayPath_tb import displayPkg::*; ();

    localparam int resetCycles   = 5;
    localparam int drainCycles   = 4;
    localparam int lastWriteWord = 2 * `FRAME_WORDS - 1;
    localparam int lastReadWord  = `FRAME_WORDS - 1;

    // One row per clock cycle
    typedef struct packed {
        logic       resetOn;
        logic       frameStart;
        logic       pixelValid;
        colorByte_t pixelColor;
        logic       request;
        readWord_t  expectData;   // Used on request rows only
    } stimRow_t;

    logic       USER_CLK;
    logic       nRES_L;
    logic       frameStart;
    logic       pixelValid;
    colorByte_t pixelColor;
    logic       request;
    readWord_t  scanData;
    logic       scanValid;

    stimRow_t  stimTable [$];
    readWord_t expectQueue [$];   // Words still owed by the DUT
    bit        tableBuilt;
    integer    seed;

    // Reference model of packer, memory and read counter
    writeWord_t modelMem [2 * `FRAME_WORDS];
    writeWord_t modelGroup;
    int         modelCount;
    int         modelWrAddr;
    int         modelRdAddr;

    displayPath DUT (
        .USER_CLK   (USER_CLK),
        .nRES_L     (nRES_L),
        .frameStart (frameStart),
        .pixelValid (pixelValid),
        .pixelColor (pixelColor),
        .request    (request),
        .scanData   (scanData),
        .scanValid  (scanValid)
    );

    bind displayPath displayPath_props props (
        .USER_CLK  (USER_CLK),
        .nRES_L    (nRES_L),
        .request   (request),
        .scanValid (scanValid),
        .scanData  (scanData)
    );

    always #2 USER_CLK = ~USER_CLK;

    task automatic stopRun();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input readWord_t got, input readWord_t want);
        if (got !== want) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, want);
            stopRun();
        end
    endtask

    // Appends a row and steps the model as the DUT will at the next edge
    task automatic addRow(input logic resetOn, input logic fs, input logic pv,
                          input colorByte_t color, input logic req);
        stimRow_t row;
        row            = '0;
        row.resetOn    = resetOn;
        row.frameStart = fs;
        row.pixelValid = pv;
        row.pixelColor = color;
        row.request    = req;
        if (resetOn) begin
            // Memory survives reset, counters do not
            modelCount  = 0;
            modelWrAddr = 0;
            modelRdAddr = 0;
        end else begin
            if (fs) begin
                modelCount  = 0;   // Partial group and same-cycle pixel are lost
                modelWrAddr = 0;
            end else if (pv) begin
                modelGroup[`PIXEL_BITS*modelCount +: `PIXEL_BITS] = color;
                modelCount++;
                if (modelCount == `PIXELS_PER_WORD) begin
                    modelMem[modelWrAddr] = modelGroup;
                    modelCount  = 0;
                    modelWrAddr = (modelWrAddr == lastWriteWord) ? 0 : modelWrAddr + 1;
                end
            end
            if (req) begin
                // Even write word low, odd write word high
                row.expectData = {modelMem[2*modelRdAddr + 1], modelMem[2*modelRdAddr]};
                modelRdAddr    = (modelRdAddr == lastReadWord) ? 0 : modelRdAddr + 1;
            end
        end
        stimTable.push_back(row);
    endtask

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            addRow(1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
        end
    endtask

    // Random colours, roughly one gap per four pixels
    task automatic writePixels(input int count);
        for (int i = 0; i < count; i++) begin
            while (($random(seed) & 3) == 0) begin
                addRow(1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
            end
            addRow(1'b0, 1'b0, 1'b1, colorByte_t'($random(seed)), 1'b0);
        end
    endtask

    // Mostly back-to-back requests with an occasional gap
    task automatic readWords(input int count);
        for (int i = 0; i < count; i++) begin
            if (($random(seed) & 7) == 0) begin
                addRow(1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
            end
            addRow(1'b0, 1'b0, 1'b0, 8'h00, 1'b1);
        end
    endtask

    // Requests words until the given one has been read
    task automatic readThrough(input int wordIndex);
        int target;
        target = (wordIndex == lastReadWord) ? 0 : wordIndex + 1;
        do begin
            addRow(1'b0, 1'b0, 1'b0, 8'h00, 1'b1);
        end while (modelRdAddr != target);
    endtask

    task automatic resetRows(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            addRow(1'b1, 1'b0, 1'b0, 8'h00, 1'b0);
        end
    endtask

    task automatic buildTable();
        modelCount  = 0;
        modelWrAddr = 0;
        modelRdAddr = 0;
        modelGroup  = '0;
        idle(3);

        // First read after reset, word 0
        writePixels(2 * `PIXELS_PER_WORD);
        idle(3);
        readWords(1);
        idle(4);

        // Whole frame, then every word plus one past the wrap
        addRow(1'b0, 1'b1, 1'b0, 8'h00, 1'b0);
        writePixels(2 * `FRAME_WORDS * `PIXELS_PER_WORD);
        idle(3);
        readWords(`FRAME_WORDS + 1);

        // Write address has wrapped, these land at 0 and 1
        writePixels(2 * `PIXELS_PER_WORD);
        idle(3);
        readThrough(0);

        // frameStart partway into a group, pixel in the same cycle
        writePixels(2);
        addRow(1'b0, 1'b1, 1'b1, 8'hee, 1'b0);
        writePixels(2 * `PIXELS_PER_WORD);
        idle(3);
        readThrough(0);

        // Mid-frame reset, memory keeps its words
        writePixels(`PIXELS_PER_WORD + 3);
        idle(3);
        resetRows(2);
        idle(2);
        readWords(1);
        writePixels(2 * `PIXELS_PER_WORD);   // Back at write address 0
        idle(3);
        readThrough(0);
        idle(4);
    endtask

    task automatic checkOutput();
        readWord_t want;
        if (scanValid === 1'b1) begin
            if (expectQueue.size() == 0) begin
                $display("scanValid high at time %0t with no request outstanding", $time);
                stopRun();
            end else begin
                want = expectQueue.pop_front();
                checkValue("scanData", scanData, want);
            end
        end
    endtask

    initial begin
        stimRow_t row;
        USER_CLK   = 1'b0;
        nRES_L     = 1'b1;
        frameStart = 1'b0;
        pixelValid = 1'b0;
        pixelColor = '0;
        request    = 1'b0;
        seed       = 32'hcc5e_585d;
        buildTable();
        tableBuilt = 1'b1;

        repeat (resetCycles) @(negedge USER_CLK);
        nRES_L = 1'b0;

        for (int i = 0; i < stimTable.size(); i++) begin
            @(negedge USER_CLK);
            checkOutput();   // Outputs are settled half a cycle after the edge
            row        = stimTable[i];
            nRES_L     = row.resetOn;
            frameStart = row.frameStart;
            pixelValid = row.pixelValid;
            pixelColor = row.pixelColor;
            request    = row.request;
            if (row.request && !row.resetOn) begin
                expectQueue.push_back(row.expectData);
            end
        end

        // Last reads still in flight
        repeat (drainCycles) begin
            @(negedge USER_CLK);
            checkOutput();
        end

        if (expectQueue.size() != 0) begin
            $display("%0d requested words never came back", expectQueue.size());
            stopRun();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // Watchdog sized from the table
    initial begin
        wait (tableBuilt);
        repeat (stimTable.size() + resetCycles + drainCycles + 100) @(posedge USER_CLK);
        $display("Timeout: the run did not finish within the cycles its table needs");
        stopRun();
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/displayPkg.sv
logic/pixelPacker.sv
logic/displayBuffer.sv
logic/scanoutReader.sv
logic/displayPath.sv
testbench/displayPath_props.sv
testbench/displayPath_tb.sv

/* Makefile */
# Frame size comes from logic/display_settings.svh

VERILATOR ?= verilator
TOP       ?= displayPath_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
